// File: verification/cpu_trace.txt
# P lines give an imem address and an instruction word
# W lines give a register and its expected write-back value in commit order
P 00 B1F0
P 01 A112
P 02 B27F
P 03 A27F
P 04 0322
P 05 4412
P 06 2543
P 07 3612
P 08 5714
P 09 6844
P 0A 7944
P 0B 918F
P 0C 8A8F
P 0D 2BA1
P 0E 1C11
P 0F 1D11
P 10 C202
P 11 BD05
P 12 C401
P 13 BDAA
P 14 D002
P 15 BE22
P 16 F000
P 17 E0F0
W 1 FFF0
W 1 12F0
W 2 007F
W 2 7F7F
W 3 7FFF
W 4 8000
W 5 8000
W 6 1270
W 7 2F00
W 8 0800
W 9 F800
W A 12F0
W B 0000
W C 25E0
W D 0005
W F 0015
W E 0022

// File: project.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/flagBranch.sv
rtl/fetchUnit.sv
rtl/memStage.sv
rtl/cpuTop.sv
verification/cpuTop_chk.sv
verification/cpuTop_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/instrDecode.sv
      - rtl/regFile.sv
      - rtl/alu.sv
      - rtl/flagBranch.sv
      - rtl/fetchUnit.sv
      - rtl/memStage.sv
      - rtl/cpuTop.sv
  - target: simulation
    files:
      - verification/cpuTop_chk.sv
      - verification/cpuTop_tb.sv

// File: verification/cpuTop_tb.sv
module cpuTop_tb;

  localparam int timeoutCycles = 2000;

  logic               clk;
  logic               arstN;
  logic               loadEn;
  cpu_pkg::imemAddr_t loadAddr;
  cpu_pkg::word_t     loadData;
  cpu_pkg::imemAddr_t pc;
  logic               wbEn;
  cpu_pkg::regAddr_t  wbAddr;
  cpu_pkg::word_t     wbData;
  logic               halted;

  // Program image and expected commits in trace order
  cpu_pkg::imemAddr_t progAddr [$];
  cpu_pkg::word_t     progWord [$];
  cpu_pkg::regAddr_t  expAddr [$];
  cpu_pkg::word_t     expData [$];
  cpu_pkg::imemAddr_t haltAddr;
  int                 errorCount;
  int                 checkCount;
  int                 cycles;

  cpuTop cpuTop_inst (
    .clk, .arstN, .loadEn, .loadAddr, .loadData, .pc, .wbEn, .wbAddr, .wbData, .halted
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // P lines fill the program and W lines queue the expected commits
  task automatic readTrace();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [15:0] a;
    logic [15:0] b;
    fd = $fopen("verification/cpu_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/cpu_trace.txt");
      errorCount++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Comment lines start with # and match neither kind
      n = $sscanf(line, "%c %h %h", kind, a, b);
      if (n == 3 && kind == "P") begin
        progAddr.push_back(cpu_pkg::imemAddr_t'(a));
        progWord.push_back(b);
        // The PC comes to rest on the HLT opcode
        if (b[15:12] == 4'hF) haltAddr = cpu_pkg::imemAddr_t'(a);
      end else if (n == 3 && kind == "W") begin
        expAddr.push_back(cpu_pkg::regAddr_t'(a));
        expData.push_back(b);
      end
    end
    $fclose(fd);
    if (progWord.size() == 0 || expAddr.size() == 0) begin
      $display("The trace holds no program words or no write-back records");
      errorCount++;
    end
  endtask

  // Compare the write in flight with the oldest expected record
  task automatic checkWriteBack();
    if (expAddr.size() == 0) begin
      $display("Write-back to register %0d at %0t is beyond the trace", wbAddr, $time);
      errorCount++;
      return;
    end
    checkCount++;
    assert (wbAddr === expAddr[0]) else begin
      $display("CHECK FAILED at %0t: wbAddr got %h expected %h", $time, wbAddr, expAddr[0]);
      errorCount++;
    end
    assert (wbData === expData[0]) else begin
      $display("CHECK FAILED at %0t: wbData got %h expected %h", $time, wbData, expData[0]);
      errorCount++;
    end
    void'(expAddr.pop_front());
    void'(expData.pop_front());
  endtask

  initial begin
    arstN      = 1'b0;
    loadEn     = 1'b0;
    loadAddr   = '0;
    loadData   = '0;
    errorCount = 0;
    checkCount = 0;
    readTrace();
    repeat (4) @(posedge clk);
    // Reset ends straight into the load so unloaded memory never runs
    arstN <= 1'b1;
    foreach (progWord[i]) begin
      loadEn   <= 1'b1;
      loadAddr <= progAddr[i];
      loadData <= progWord[i];
      @(posedge clk);
    end
    loadEn <= 1'b0;
    // Mid-cycle values are the ones committed on the next rising edge
    cycles = 0;
    while (!halted && cycles < timeoutCycles) begin
      @(negedge clk);
      cycles++;
      if (wbEn) checkWriteBack();
    end
    if (!halted) begin
      $display("Timed out after %0d cycles with halted still low", timeoutCycles);
      errorCount++;
    end
    if (expAddr.size() != 0) begin
      $display("%0d expected write-backs never happened", expAddr.size());
      errorCount++;
    end
    // Halted core keeps issuing the bubble and holds its PC on the HLT
    repeat (4) begin
      @(negedge clk);
      assert (wbEn === 1'b0) else begin
        $display("CHECK FAILED at %0t: wbEn got %b expected 0", $time, wbEn);
        errorCount++;
      end
      assert (pc === haltAddr) else begin
        $display("CHECK FAILED at %0t: pc got %h expected %h", $time, pc, haltAddr);
        errorCount++;
      end
    end
    $display("Write-back checks %0d, errors %0d, assertion failures %0d",
             checkCount, errorCount, cpuTop_inst.cpuTop_chk_inst.failCount);
    if (errorCount == 0 && cpuTop_inst.cpuTop_chk_inst.failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: verification/cpuTop_chk.sv
module cpuTop_chk (
  input logic               clk,
  input logic               arstN,
  input logic               loadEn,
  input cpu_pkg::imemAddr_t pc,
  input logic               wbEn,
  input logic               halted
);

  int failCount = 0;

  // Halt is sticky until the next reset
  haltSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted) else begin
    failCount++;
    $error("halted fell while out of reset");
  end

  // A halted core keeps its PC
  pcHeld: assert property (@(posedge clk) disable iff (!arstN) halted |=> $stable(pc)) else begin
    failCount++;
    $error("pc moved while halted");
  end

  // Load bubble commits no register write
  loadQuiet: assert property (@(posedge clk) disable iff (!arstN) loadEn |-> !wbEn) else begin
    failCount++;
    $error("wbEn high during program load");
  end

endmodule

bind cpuTop cpuTop_chk cpuTop_chk_inst (.clk, .arstN, .loadEn, .pc, .wbEn, .halted);

// File: rtl/cpuTop.sv
`include "cpu_settings.svh"

module cpuTop (
  input  logic               clk,
  input  logic               arstN,
  input  logic               loadEn,
  input  cpu_pkg::imemAddr_t loadAddr,
  input  cpu_pkg::word_t     loadData,
  output cpu_pkg::imemAddr_t pc,
  output logic               wbEn,
  output cpu_pkg::regAddr_t  wbAddr,
  output cpu_pkg::word_t     wbData,
  output logic               halted
);

  cpu_pkg::word_t       instr;
  cpu_pkg::word_t       linkAddr;
  logic [11:0]          imm;
  cpu_pkg::regAddr_t    p0Addr;
  cpu_pkg::regAddr_t    p1Addr;
  logic [3:0]           shamt;
  cpu_pkg::aluOp_t      aluOp;
  cpu_pkg::branchCond_t branchOp;
  logic                 regWe, memWe, memToReg, addz, branch, jal, jr, hlt;
  logic                 aluSrc0, aluSrc1, ovEn, zrEn, neEn;
  cpu_pkg::word_t       p0Data, p1Data;
  cpu_pkg::word_t       src0, src1, aluResult;
  logic                 zero, ovfl, neg, takeBranch;

  fetchUnit fetchUnit_inst (
    .clk, .arstN, .loadEn, .loadAddr, .loadData, .takeBranch, .jal, .jr, .hlt,
    .imm, .jrTarget(p0Data), .instr, .pc, .linkAddr, .halted
  );

  instrDecode instrDecode_inst (
    .instr, .imm, .p0Addr, .p1Addr, .regAddr(wbAddr), .shamt, .aluOp, .branchOp,
    .regWe, .memWe, .memToReg, .addz, .branch, .jal, .jr, .hlt,
    .aluSrc0, .aluSrc1, .ovEn, .zrEn, .neEn
  );

  regFile regFile_inst (
    .clk, .arstN, .p0Addr, .p1Addr, .wrAddr(wbAddr), .wrEn(wbEn), .wrData(wbData),
    .p0Data, .p1Data
  );

  // LLB and LHB take the sign-extended byte, LW and SW the nibble offset
  assign src0 = aluSrc0 ? {{8{imm[7]}}, imm[7:0]} : p0Data;
  assign src1 = aluSrc1 ? {{12{imm[3]}}, imm[3:0]} : p1Data;

  alu alu_inst (
    .src0, .src1, .shamt, .aluOp, .result(aluResult), .zero, .ovfl, .neg
  );

  flagBranch flagBranch_inst (
    .clk, .arstN, .zero, .ovfl, .neg, .zrEn, .ovEn, .neEn,
    .branch, .branchOp, .addz, .regWe, .takeBranch, .wbEn
  );

  // Data address is the low byte of base plus offset
  memStage memStage_inst (
    .clk, .memWe, .memToReg, .jal, .addr(aluResult[`CPU_DMEM_AW-1:0]),
    .storeData(p1Data), .aluResult, .linkAddr, .wbData
  );

endmodule

// File: rtl/memStage.sv
`include "cpu_settings.svh"

module memStage (
  input  logic               clk,
  input  logic               memWe,
  input  logic               memToReg,
  input  logic               jal,
  input  cpu_pkg::dmemAddr_t addr,
  input  cpu_pkg::word_t     storeData,
  input  cpu_pkg::word_t     aluResult,
  input  cpu_pkg::word_t     linkAddr,
  output cpu_pkg::word_t     wbData
);

  cpu_pkg::word_t dmem [2**`CPU_DMEM_AW];
  cpu_pkg::word_t loadWord;

  // SW commits at the end of its cycle
  always_ff @(posedge clk) begin
    if (memWe) dmem[addr] <= storeData;
  end

  // Asynchronous read so LW finishes in one cycle
  assign loadWord = dmem[addr];

  // Write-back source
  // Link address for JAL, loaded word for LW, else the ALU
  assign wbData = jal      ? linkAddr :
                  memToReg ? loadWord : aluResult;

endmodule

// File: rtl/fetchUnit.sv
`include "cpu_settings.svh"

module fetchUnit (
  input  logic               clk,
  input  logic               arstN,
  input  logic               loadEn,
  input  cpu_pkg::imemAddr_t loadAddr,
  input  cpu_pkg::word_t     loadData,
  input  logic               takeBranch,
  input  logic               jal,
  input  logic               jr,
  input  logic               hlt,
  input  logic [11:0]        imm,
  input  cpu_pkg::word_t     jrTarget,
  output cpu_pkg::word_t     instr,
  output cpu_pkg::imemAddr_t pc,
  output cpu_pkg::word_t     linkAddr,
  output logic               halted
);

  // HLT with zero operands, writes nothing anywhere
  localparam cpu_pkg::word_t hltBubble = 16'hF000;

  cpu_pkg::word_t     imem [2**`CPU_IMEM_AW];
  cpu_pkg::word_t     brOffset;
  cpu_pkg::word_t     jalOffset;
  cpu_pkg::imemAddr_t pcPlus1;
  cpu_pkg::imemAddr_t nextPc;

  // Program load port
  always_ff @(posedge clk) begin
    if (loadEn) imem[loadAddr] <= loadData;
  end

  assign instr = (loadEn || halted) ? hltBubble : imem[pc];

  assign pcPlus1   = pc + 1'b1;
  assign linkAddr  = {{(16 - `CPU_IMEM_AW){1'b0}}, pcPlus1};
  assign brOffset  = {{7{imm[8]}}, imm[8:0]};
  assign jalOffset = {{4{imm[11]}}, imm};

  // Offsets wrap within the program space
  assign nextPc = jr         ? jrTarget[`CPU_IMEM_AW-1:0] :
                  jal        ? pcPlus1 + jalOffset[`CPU_IMEM_AW-1:0] :
                  takeBranch ? pcPlus1 + brOffset[`CPU_IMEM_AW-1:0] : pcPlus1;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (loadEn) begin
      pc <= '0;
    end else if (hlt) begin
      // Real HLT, or the bubble once halted, so PC holds
      halted <= 1'b1;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

// File: rtl/flagBranch.sv
module flagBranch (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 zero,
  input  logic                 ovfl,
  input  logic                 neg,
  input  logic                 zrEn,
  input  logic                 ovEn,
  input  logic                 neEn,
  input  logic                 branch,
  input  cpu_pkg::branchCond_t branchOp,
  input  logic                 addz,
  input  logic                 regWe,
  output logic                 takeBranch,
  output logic                 wbEn
);

  logic zFlag;
  logic vFlag;
  logic nFlag;
  logic condMet;

  // Flag register, each bit under its own enable
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      zFlag <= 1'b0;
      vFlag <= 1'b0;
      nFlag <= 1'b0;
    end else begin
      if (zrEn) zFlag <= zero;
      if (ovEn) vFlag <= ovfl;
      if (neEn) nFlag <= neg;
    end
  end

  // Conditions test the stored flags from earlier instructions
  always_comb begin
    case (branchOp)
      3'b000:  condMet = !zFlag;
      3'b001:  condMet = zFlag;
      3'b010:  condMet = !zFlag && !nFlag;
      3'b011:  condMet = nFlag;
      3'b100:  condMet = zFlag || !nFlag;
      3'b101:  condMet = nFlag || zFlag;
      3'b110:  condMet = vFlag;
      default: condMet = 1'b1;
    endcase
  end

  assign takeBranch = branch && condMet;

  // ADDZ commits only while Z holds from before it
  assign wbEn = regWe || (addz && zFlag);

endmodule

// File: rtl/alu.sv
module alu (
  input  cpu_pkg::word_t  src0,
  input  cpu_pkg::word_t  src1,
  input  logic [3:0]      shamt,
  input  cpu_pkg::aluOp_t aluOp,
  output cpu_pkg::word_t  result,
  output logic            zero,
  output logic            ovfl,
  output logic            neg
);

  cpu_pkg::word_t sum;
  cpu_pkg::word_t diff;
  cpu_pkg::word_t satSum;
  cpu_pkg::word_t satDiff;
  logic           sumOv;
  logic           diffOv;

  assign sum  = src0 + src1;
  assign diff = src0 - src1;

  // Add overflows when like signs give an unlike result
  assign sumOv  = (src0[15] == src1[15]) && (sum[15] != src0[15]);
  // Sub overflows when unlike signs flip the sign of src0
  assign diffOv = (src0[15] != src1[15]) && (diff[15] != src0[15]);

  // Clamp toward the sign of src0
  assign satSum  = !sumOv  ? sum  : (src0[15] ? 16'h8000 : 16'h7FFF);
  assign satDiff = !diffOv ? diff : (src0[15] ? 16'h8000 : 16'h7FFF);

  always_comb begin
    case (aluOp)
      cpu_pkg::aluAdd: result = satSum;
      // Immediate byte on top, destination low byte kept
      cpu_pkg::aluLhb: result = {src0[7:0], src1[7:0]};
      cpu_pkg::aluSub: result = satDiff;
      cpu_pkg::aluAnd: result = src0 & src1;
      cpu_pkg::aluNor: result = ~(src0 | src1);
      cpu_pkg::aluSll: result = src0 << shamt;
      cpu_pkg::aluSrl: result = src0 >> shamt;
      cpu_pkg::aluSra: result = $signed(src0) >>> shamt;
      default:         result = satSum;
    endcase
  end

  // Raw flags, the decoder enables decide which ones stick
  assign zero = result == '0;
  assign neg  = result[15];
  assign ovfl = ((aluOp == cpu_pkg::aluAdd) && sumOv) ||
                ((aluOp == cpu_pkg::aluSub) && diffOv);

endmodule

// File: rtl/regFile.sv
`include "cpu_settings.svh"

module regFile (
  input  logic              clk,
  input  logic              arstN,
  input  cpu_pkg::regAddr_t p0Addr,
  input  cpu_pkg::regAddr_t p1Addr,
  input  cpu_pkg::regAddr_t wrAddr,
  input  logic              wrEn,
  input  cpu_pkg::word_t    wrData,
  output cpu_pkg::word_t    p0Data,
  output cpu_pkg::word_t    p1Data
);

  cpu_pkg::word_t regs [`CPU_REG_COUNT];

  // Single write port, committed at the end of the instruction
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      // R0 never takes a write
      regs[wrAddr] <= wrData;
    end
  end

  // Combinational reads
  // R0 forced to zero on both ports
  assign p0Data = (p0Addr == '0) ? '0 : regs[p0Addr];
  assign p1Data = (p1Addr == '0) ? '0 : regs[p1Addr];

endmodule

// File: rtl/instrDecode.sv
module instrDecode (
  input  cpu_pkg::word_t       instr,
  output logic [11:0]          imm,
  output cpu_pkg::regAddr_t    p0Addr,
  output cpu_pkg::regAddr_t    p1Addr,
  output cpu_pkg::regAddr_t    regAddr,
  output logic [3:0]           shamt,
  output cpu_pkg::aluOp_t      aluOp,
  output cpu_pkg::branchCond_t branchOp,
  output logic                 regWe,
  output logic                 memWe,
  output logic                 memToReg,
  output logic                 addz,
  output logic                 branch,
  output logic                 jal,
  output logic                 jr,
  output logic                 hlt,
  output logic                 aluSrc0,
  output logic                 aluSrc1,
  output logic                 ovEn,
  output logic                 zrEn,
  output logic                 neEn
);

  logic [3:0] opcode;
  logic       add;
  logic       sub;
  logic       lw;
  logic       sw;
  logic       lhb;
  logic       llb;

  assign opcode = instr[15:12];

  // One-hot opcode strobes
  assign add    = opcode == 4'b0000;
  assign addz   = opcode == 4'b0001;
  assign sub    = opcode == 4'b0010;
  assign lw     = opcode == 4'b1000;
  assign sw     = opcode == 4'b1001;
  assign lhb    = opcode == 4'b1010;
  assign llb    = opcode == 4'b1011;
  assign branch = opcode == 4'b1100;
  assign jal    = opcode == 4'b1101;
  assign jr     = opcode == 4'b1110;
  assign hlt    = opcode == 4'b1111;

  assign imm   = instr[11:0];
  assign shamt = instr[3:0];

  // Base register for ALU ops, LW, SW and JR
  assign p0Addr = instr[7:4];
  // SW store data and LHB merge come from instr[11:8]
  // LLB adds the immediate to R0
  assign p1Addr = (sw || lhb) ? instr[11:8] :
                  llb         ? 4'h0        : instr[3:0];

  // JAL links into R15
  assign regAddr = jal ? 4'hF : instr[11:8];

  // ADDZ writes only through the Z check in flagBranch
  // HLT is also the bubble, so it never writes
  assign regWe    = !addz && !sw && !branch && !jr && !hlt;
  assign memWe    = sw;
  assign memToReg = lw;

  // Z for every ALU opcode, V and N for arithmetic only
  assign ovEn = add || addz || sub;
  assign neEn = ovEn;
  assign zrEn = !opcode[3];

  // Byte immediate into src0, nibble offset into src1
  assign aluSrc0 = llb || lhb;
  assign aluSrc1 = lw || sw;

  assign branchOp = instr[11:9];

  always_comb begin
    if (!opcode[3]) begin
      aluOp = addz ? cpu_pkg::aluAdd : opcode[2:0];
    end else if (lhb) begin
      aluOp = cpu_pkg::aluLhb;
    end else begin
      // LLB, LW, SW and the control ops all add
      aluOp = cpu_pkg::aluAdd;
    end
  end

endmodule

// File: rtl/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  // Data or instruction word
  typedef logic [15:0] word_t;
  // Register index
  typedef logic [3:0] regAddr_t;
  // ALU function code
  typedef logic [2:0] aluOp_t;
  // Branch condition field, instr[11:9]
  typedef logic [2:0] branchCond_t;
  // Memory addresses
  typedef logic [`CPU_IMEM_AW-1:0] imemAddr_t;
  typedef logic [`CPU_DMEM_AW-1:0] dmemAddr_t;

  // ALU codes, arithmetic and logic match the low opcode bits
  localparam aluOp_t aluAdd = 3'b000;
  localparam aluOp_t aluLhb = 3'b001;
  localparam aluOp_t aluSub = 3'b010;
  localparam aluOp_t aluAnd = 3'b011;
  localparam aluOp_t aluNor = 3'b100;
  localparam aluOp_t aluSll = 3'b101;
  localparam aluOp_t aluSrl = 3'b110;
  localparam aluOp_t aluSra = 3'b111;

endpackage

// File: rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Instruction memory address width
// 256 words of program space
`define CPU_IMEM_AW 8

// Data memory address width
`define CPU_DMEM_AW 8

// Architectural register count, R0 reads as zero
`define CPU_REG_COUNT 16

`endif
